// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_cadr
FILELIST  = build.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
rtl/cadr_pkg.sv
rtl/machine_ctl.sv
rtl/micro_sequencer.sv
rtl/scratch_mem.sv
rtl/alu.sv
rtl/spy_port.sv
rtl/cadr_top.sv
tests/cadr_checker.sv
tests/tb_cadr.sv

// ==== rtl/alu.sv ====
// ALU functions, LOAD constant path, ob register and the a == m compare
module alu (
   input  logic             clk,
   input  logic             reset,
   input  cadr_pkg::cycle_e cycle,
   input  cadr_pkg::uinst_t ir,
   input  cadr_pkg::word_t  a,          // A latch
   input  cadr_pkg::word_t  m,          // M latch
   output cadr_pkg::word_t  ob,
   output logic             aeqm
);

   cadr_pkg::uop_e  op;
   cadr_pkg::aluf_e aluf;
   cadr_pkg::word_t const_word;
   cadr_pkg::word_t result;
   logic            load_ob;

   assign op         = cadr_pkg::uop_e'(ir[cadr_pkg::OP_LSB +: 2]);
   assign aluf       = cadr_pkg::aluf_e'(ir[cadr_pkg::ALUF_LSB +: 3]);
   assign const_word = cadr_pkg::word_t'(ir[cadr_pkg::CONST_LSB +: cadr_pkg::CONST_W]);

   ////////////////////////////////////////
   // Function select

   always_comb begin
      case (aluf)
         cadr_pkg::ALU_SETA: result = a;
         cadr_pkg::ALU_SETM: result = m;
         cadr_pkg::ALU_ADD:  result = a + m;
         cadr_pkg::ALU_SUB:  result = a - m;
         cadr_pkg::ALU_AND:  result = a & m;
         cadr_pkg::ALU_OR:   result = a | m;
         cadr_pkg::ALU_XOR:  result = a ^ m;
         default:            result = m + 1'b1;          // ALU_INCM
      endcase
      if (op == cadr_pkg::OP_LOAD)
         result = const_word;                            // Immediate overrides aluf
   end

   // JUMP and HALT leave ob alone
   assign load_ob = (cycle == cadr_pkg::CYC_ALU) &&
                    ((op == cadr_pkg::OP_ALU) || (op == cadr_pkg::OP_LOAD));

   always_ff @(posedge clk) begin
      if (reset)
         ob <= '0;
      else if (load_ob)
         ob <= result;
   end

   // Latches are stable from end of read to next read
   assign aeqm = (a == m);

endmodule

// ==== rtl/cadr_pkg.sv ====
// Widths, microinstruction layout and encodings shared by every module of the CADR core
package cadr_pkg;

   ////////////////////////////////////////
   // Widths

   localparam int UPC_W         = 10;   // Micro PC and control store address
   localparam int SCRATCH_ADR_W = 4;    // Default scratchpad address
   localparam int WORD_W        = 32;   // Data path
   localparam int CONST_W       = 16;   // LOAD immediate
   localparam int SPY_W         = 16;   // One spy read

   typedef logic [31:0]       uinst_t;  // Microinstruction
   typedef logic [WORD_W-1:0] word_t;   // a, m, ob
   typedef logic [UPC_W-1:0]  upc_t;    // Micro PC
   typedef logic [SPY_W-1:0]  spy_t;    // Spy word

   ////////////////////////////////////////
   // Microinstruction fields, low bit of each

   localparam int OP_LSB       = 30;    // op, 2 bits
   localparam int ALUF_LSB     = 27;    // aluf, 3 bits
   localparam int DEST_M_BIT   = 26;    // 1 = M memory, 0 = A memory
   localparam int DEST_ADR_LSB = 22;    // dest_adr, 4 bits
   localparam int A_ADR_LSB    = 18;    // a_adr, 4 bits
   localparam int M_ADR_LSB    = 14;    // m_adr, 4 bits
   localparam int JCOND_LSB    = 12;    // jcond, 2 bits
   localparam int TARGET_LSB   = 0;     // Jump target, UPC_W bits
   localparam int CONST_LSB    = 0;     // LOAD only, overlaps the other low fields

   ////////////////////////////////////////
   // Encodings

   typedef enum logic [1:0] {
      OP_ALU,                           // ob = f(a, m), optional write back
      OP_JUMP,                          // Conditional branch on a == m
      OP_LOAD,                          // ob = zero-extended constant
      OP_HALT                           // Stop in fetch
   } uop_e;

   typedef enum logic [2:0] {
      ALU_SETA,
      ALU_SETM,
      ALU_ADD,
      ALU_SUB,                          // a - m
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_INCM                          // m + 1
   } aluf_e;

   typedef enum logic [1:0] {
      J_ALWAYS,
      J_AEQM,
      J_ANEM,
      J_NEVER
   } jcond_e;

   // Major cycle of one microinstruction
   typedef enum logic [2:0] {
      CYC_RESET,
      CYC_DECODE,
      CYC_READ,
      CYC_ALU,
      CYC_WRITE,
      CYC_FETCH
   } cycle_e;

   typedef enum logic [2:0] {
      SPY_PC,
      SPY_IRL,
      SPY_IRH,
      SPY_OBL,
      SPY_OBH,
      SPY_STATUS
   } spy_sel_e;

endpackage

// ==== rtl/cadr_top.sv ====
// Top level of the cut-down CADR core; wires sequencer, scratchpads, ALU and spy port
module cadr_top #(
   parameter int CS_DEPTH = 1024,                      // Control store words
   parameter int A_ADR_W  = cadr_pkg::SCRATCH_ADR_W,   // A memory address
   parameter int M_ADR_W  = cadr_pkg::SCRATCH_ADR_W    // M memory address, may be smaller
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               boot,
   input  logic               ext_halt,
   input  logic               ucode_we,
   input  cadr_pkg::upc_t     ucode_addr,
   input  cadr_pkg::uinst_t   ucode_data,
   input  cadr_pkg::spy_sel_e spy_sel,
   output cadr_pkg::upc_t     pc,
   output logic               machrun,
   output cadr_pkg::spy_t     spy_out
);

   cadr_pkg::cycle_e cycle;
   cadr_pkg::uinst_t ir;
   cadr_pkg::uop_e   op;
   cadr_pkg::word_t  a;
   cadr_pkg::word_t  m;
   cadr_pkg::word_t  ob;
   logic             fetch_zero;
   logic             halt_op;
   logic             aeqm;
   logic             writes_ob;
   logic             a_wr_en;
   logic             m_wr_en;

   ////////////////////////////////////////
   // Write-back select

   assign op        = cadr_pkg::uop_e'(ir[cadr_pkg::OP_LSB +: 2]);
   assign writes_ob = (op == cadr_pkg::OP_ALU) || (op == cadr_pkg::OP_LOAD);
   assign a_wr_en   = writes_ob && !ir[cadr_pkg::DEST_M_BIT];
   assign m_wr_en   = writes_ob && ir[cadr_pkg::DEST_M_BIT];

   machine_ctl u_machine_ctl (
      .clk        (clk),
      .reset      (reset),
      .boot       (boot),
      .ext_halt   (ext_halt),
      .halt_op    (halt_op),
      .cycle      (cycle),
      .machrun    (machrun),
      .fetch_zero (fetch_zero)
   );

   micro_sequencer #(.CS_DEPTH(CS_DEPTH)) u_micro_sequencer (
      .clk        (clk),
      .reset      (reset),
      .cycle      (cycle),
      .machrun    (machrun),
      .fetch_zero (fetch_zero),
      .aeqm       (aeqm),
      .ucode_we   (ucode_we),
      .ucode_addr (ucode_addr),
      .ucode_data (ucode_data),
      .ir         (ir),
      .pc         (pc),
      .halt_op    (halt_op)
   );

   scratch_mem #(.ADR_W(A_ADR_W)) amem (
      .clk     (clk),
      .reset   (reset),
      .cycle   (cycle),
      .rd_adr  (ir[cadr_pkg::A_ADR_LSB +: A_ADR_W]),
      .wr_adr  (ir[cadr_pkg::DEST_ADR_LSB +: A_ADR_W]),
      .wr_en   (a_wr_en),
      .wr_data (ob),
      .rd_data (a)
   );

   scratch_mem #(.ADR_W(M_ADR_W)) mmem (
      .clk     (clk),
      .reset   (reset),
      .cycle   (cycle),
      .rd_adr  (ir[cadr_pkg::M_ADR_LSB +: M_ADR_W]),
      .wr_adr  (ir[cadr_pkg::DEST_ADR_LSB +: M_ADR_W]),
      .wr_en   (m_wr_en),
      .wr_data (ob),
      .rd_data (m)
   );

   alu u_alu (
      .clk   (clk),
      .reset (reset),
      .cycle (cycle),
      .ir    (ir),
      .a     (a),
      .m     (m),
      .ob    (ob),
      .aeqm  (aeqm)
   );

   spy_port u_spy_port (
      .spy_sel (spy_sel),
      .pc      (pc),
      .ir      (ir),
      .ob      (ob),
      .cycle   (cycle),
      .machrun (machrun),
      .spy_out (spy_out)
   );

endmodule

// ==== rtl/machine_ctl.sv ====
// Cycle state machine and run flip-flop; steps decode, read, ALU, write, fetch while running
module machine_ctl (
   input  logic             clk,
   input  logic             reset,
   input  logic             boot,        // One-cycle start pulse
   input  logic             ext_halt,    // Level, sampled in write
   input  logic             halt_op,     // IR holds OP_HALT
   output cadr_pkg::cycle_e cycle,
   output logic             machrun,
   output logic             fetch_zero   // Boot fetch from address 0
);

   cadr_pkg::cycle_e next_cycle;
   logic             run_set;
   logic             run_clr;

   // Boot only taken while stopped in decode
   assign run_set = boot && !machrun && (cycle == cadr_pkg::CYC_DECODE);

   // External halt ends after write, HALT op ends in its own fetch
   assign run_clr = ((cycle == cadr_pkg::CYC_WRITE) && ext_halt) ||
                    ((cycle == cadr_pkg::CYC_FETCH) && halt_op && !fetch_zero);

   ////////////////////////////////////////
   // Next cycle

   always_comb begin
      next_cycle = cadr_pkg::CYC_DECODE;                // Also the stopped state
      case (cycle)
         cadr_pkg::CYC_RESET:  next_cycle = cadr_pkg::CYC_DECODE;
         cadr_pkg::CYC_DECODE: begin
            if (run_set)
               next_cycle = cadr_pkg::CYC_FETCH;         // Load IR from 0
            else if (machrun)
               next_cycle = cadr_pkg::CYC_READ;
            else
               next_cycle = cadr_pkg::CYC_DECODE;        // Idle
         end
         cadr_pkg::CYC_READ:   next_cycle = cadr_pkg::CYC_ALU;
         cadr_pkg::CYC_ALU:    next_cycle = cadr_pkg::CYC_WRITE;
         cadr_pkg::CYC_WRITE:  next_cycle = ext_halt ? cadr_pkg::CYC_DECODE  // Skip fetch
                                                     : cadr_pkg::CYC_FETCH;
         cadr_pkg::CYC_FETCH:  next_cycle = cadr_pkg::CYC_DECODE;
         default:              next_cycle = cadr_pkg::CYC_DECODE;
      endcase
   end

   ////////////////////////////////////////
   // State and run registers

   always_ff @(posedge clk) begin
      if (reset) begin
         cycle      <= cadr_pkg::CYC_RESET;
         machrun    <= 1'b0;
         fetch_zero <= 1'b0;
      end else begin
         cycle      <= next_cycle;
         fetch_zero <= run_set;                          // High for the boot fetch only
         if (run_set)
            machrun <= 1'b1;
         else if (run_clr)
            machrun <= 1'b0;
      end
   end

   a_cycle_legal: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(cycle) && (cycle <= cadr_pkg::CYC_FETCH))
      else $error("illegal cycle code %0d", cycle);

   // Run flop and state register must leave reset together
   a_no_run_in_reset: assert property (@(posedge clk)
      (cycle == cadr_pkg::CYC_RESET) |-> !machrun)
      else $error("machrun high in reset cycle");

endmodule

// ==== rtl/micro_sequencer.sv ====
// Writable control store, instruction register and micro PC with jump selection
module micro_sequencer #(
   parameter int CS_DEPTH = 1024        // Control store words
) (
   input  logic             clk,
   input  logic             reset,
   input  cadr_pkg::cycle_e cycle,
   input  logic             machrun,
   input  logic             fetch_zero,
   input  logic             aeqm,       // From the ALU compare
   input  logic             ucode_we,   // Load strobe, stopped only
   input  cadr_pkg::upc_t   ucode_addr,
   input  cadr_pkg::uinst_t ucode_data,
   output cadr_pkg::uinst_t ir,
   output cadr_pkg::upc_t   pc,
   output logic             halt_op
);

   cadr_pkg::uinst_t cstore [CS_DEPTH];
   cadr_pkg::uop_e   op;
   cadr_pkg::jcond_e jcond;
   cadr_pkg::upc_t   target;
   cadr_pkg::upc_t   next_pc;
   logic             cond_true;
   logic             jump_taken;
   logic             load_ir;

   ////////////////////////////////////////
   // IR decode

   assign op      = cadr_pkg::uop_e'(ir[cadr_pkg::OP_LSB +: 2]);
   assign jcond   = cadr_pkg::jcond_e'(ir[cadr_pkg::JCOND_LSB +: 2]);
   assign target  = ir[cadr_pkg::TARGET_LSB +: cadr_pkg::UPC_W];
   assign halt_op = (op == cadr_pkg::OP_HALT);

   always_comb begin
      case (jcond)
         cadr_pkg::J_ALWAYS: cond_true = 1'b1;
         cadr_pkg::J_AEQM:   cond_true = aeqm;
         cadr_pkg::J_ANEM:   cond_true = !aeqm;
         default:            cond_true = 1'b0;           // J_NEVER
      endcase
   end

   assign jump_taken = (op == cadr_pkg::OP_JUMP) && cond_true;

   // Boot wins, then jump, else fall through
   assign next_pc = fetch_zero ? '0 :
                    jump_taken ? target :
                    pc + 1'b1;

   // A HALT keeps pc and ir on its own address
   assign load_ir = (cycle == cadr_pkg::CYC_FETCH) &&
                    (fetch_zero || (machrun && !halt_op));

   ////////////////////////////////////////
   // Control store

   always_ff @(posedge clk) begin
      if (ucode_we && !machrun)
         cstore[ucode_addr] <= ucode_data;               // Loader port
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ir <= '0;
         pc <= '0;
      end else if (load_ir) begin
         ir <= cstore[next_pc];                          // Registered read
         pc <= next_pc;
      end
   end

   // Loader has to wait until the core is stopped
   a_no_load_running: assert property (@(posedge clk) disable iff (reset)
      machrun |-> !ucode_we)
      else $error("control store write while machine running");

endmodule

// ==== rtl/scratch_mem.sv ====
// One scratchpad with its output latch; instantiated for the A and the M memory
module scratch_mem #(
   parameter int ADR_W = cadr_pkg::SCRATCH_ADR_W
) (
   input  logic             clk,
   input  logic             reset,
   input  cadr_pkg::cycle_e cycle,
   input  logic [ADR_W-1:0] rd_adr,     // IR source field
   input  logic [ADR_W-1:0] wr_adr,     // IR dest field
   input  logic             wr_en,      // Dest selects this memory
   input  cadr_pkg::word_t  wr_data,    // ob
   output cadr_pkg::word_t  rd_data     // Latched a or m
);

   cadr_pkg::word_t  mem [2**ADR_W];
   logic [ADR_W-1:0] rd_adr_q;

   // Source address captured in decode
   always_ff @(posedge clk) begin
      if (reset)
         rd_adr_q <= '0;
      else if (cycle == cadr_pkg::CYC_DECODE)
         rd_adr_q <= rd_adr;
   end

   ////////////////////////////////////////
   // Array and read latch

   always_ff @(posedge clk) begin
      if (cycle == cadr_pkg::CYC_READ)
         rd_data <= mem[rd_adr_q];                       // Holds through fetch
      if (wr_en && (cycle == cadr_pkg::CYC_WRITE))
         mem[wr_adr] <= wr_data;                         // Done before next decode
   end

endmodule

// ==== rtl/spy_port.sv ====
// Spy read mux; returns 16 bits of PC, IR, ob or run status for the debug host
module spy_port (
   input  cadr_pkg::spy_sel_e spy_sel,
   input  cadr_pkg::upc_t     pc,
   input  cadr_pkg::uinst_t   ir,
   input  cadr_pkg::word_t    ob,
   input  cadr_pkg::cycle_e   cycle,
   input  logic               machrun,
   output cadr_pkg::spy_t     spy_out
);

   cadr_pkg::spy_t status;

   // Bit 0 run flag, bits 3..1 cycle code
   assign status = {12'b0, cycle, machrun};

   always_comb begin
      case (spy_sel)
         cadr_pkg::SPY_PC:     spy_out = cadr_pkg::spy_t'(pc);   // Zero extended
         cadr_pkg::SPY_IRL:    spy_out = ir[15:0];
         cadr_pkg::SPY_IRH:    spy_out = ir[31:16];
         cadr_pkg::SPY_OBL:    spy_out = ob[15:0];
         cadr_pkg::SPY_OBH:    spy_out = ob[31:16];
         cadr_pkg::SPY_STATUS: spy_out = status;
         default:              spy_out = '0;                     // Unused codes
      endcase
   end

endmodule

// ==== tests/cadr_checker.sv ====
// Testbench checker for the CADR core; compares pc, run flag and spy words with posted values
module cadr_checker (
   input  logic               clk,
   input  logic               reset,
   input  cadr_pkg::upc_t     pc,          // DUT outputs
   input  logic               machrun,
   input  cadr_pkg::spy_t     spy_out,
   input  cadr_pkg::spy_sel_e spy_sel,     // Select driven into the DUT
   input  logic               cmp_en,      // Posted values valid this cycle
   input  cadr_pkg::spy_t     exp_spy,
   input  cadr_pkg::upc_t     exp_pc,
   input  logic               stall,       // Run did not stop in time
   input  int                 case_id,
   output int                 errors,
   output int                 checks
);

   timeunit 1ns;
   timeprecision 1ps;

   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      $display("CHECK FAILED t=%0t case %0d %s got %0h expected %0h",
               $time, case_id, name, got, want);
      errors++;
   endtask

   ////////////////////////////////////////
   // Compare on the clock edge

   // Inputs move 2 ns after the edge so all values are settled here
   always @(posedge clk) begin
      if (reset) begin
         errors = 0;
         checks = 0;
      end else begin
         if (cmp_en) begin
            checks++;
            if (spy_out !== exp_spy)
               flag_mismatch($sformatf("spy_out[%s]", spy_sel.name()),
                             32'(spy_out), 32'(exp_spy));
            if (pc !== exp_pc)
               flag_mismatch("pc", 32'(pc), 32'(exp_pc));
            if (machrun !== 1'b0)
               flag_mismatch("machrun", 32'(machrun), 32'd0);   // Read-back only when stopped
         end
         if (stall) begin
            $display("t=%0t case %0d: machrun stayed high, the machine never stopped",
                     $time, case_id);
            errors++;
         end
      end
   end

endmodule

// ==== tests/tb_cadr.sv ====
// Testbench for cadr_top; loads a table of microprograms, boots each one and reads back state
module tb_cadr;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          N_CASES      = 16;     // 8 ALU, 6 jump, loop, ext halt
   localparam int          PROG_LEN     = 16;     // Words loaded per case
   localparam int          RESET_CYCLES = 16;
   localparam int          RUN_LIMIT    = 80;     // Cycles allowed from boot to halt
   localparam int          EXT_DELAY    = 30;     // Spin cycles before ext_halt
   localparam int          WATCHDOG     = RESET_CYCLES + N_CASES * (PROG_LEN * 5 + 40);
   localparam logic [15:0] LOOP_N       = 16'd5;  // Loop limit in A[4]
   localparam cadr_pkg::spy_t STOPPED   = {12'h000, cadr_pkg::CYC_DECODE, 1'b0};

   logic               clk;
   logic               reset;
   logic               boot;
   logic               ext_halt;
   logic               ucode_we;
   cadr_pkg::upc_t     ucode_addr;
   cadr_pkg::uinst_t   ucode_data;
   cadr_pkg::spy_sel_e spy_sel;
   cadr_pkg::upc_t     pc;
   logic               machrun;
   cadr_pkg::spy_t     spy_out;

   logic               cmp_en;           // To the checker
   cadr_pkg::spy_t     post_spy;
   cadr_pkg::upc_t     post_pc;
   logic               stall;
   int                 case_id;
   int                 err_count;
   int                 check_count;
   bit                 stalled;

   // Stimulus table
   cadr_pkg::uinst_t   prog     [N_CASES][PROG_LEN];
   cadr_pkg::word_t    case_ob  [N_CASES];
   cadr_pkg::upc_t     case_pc  [N_CASES];
   bit                 case_ext [N_CASES];

   cadr_top #(.CS_DEPTH(1024)) DUT (
      .clk        (clk),
      .reset      (reset),
      .boot       (boot),
      .ext_halt   (ext_halt),
      .ucode_we   (ucode_we),
      .ucode_addr (ucode_addr),
      .ucode_data (ucode_data),
      .spy_sel    (spy_sel),
      .pc         (pc),
      .machrun    (machrun),
      .spy_out    (spy_out)
   );

   cadr_checker u_checker (
      .clk     (clk),
      .reset   (reset),
      .pc      (pc),
      .machrun (machrun),
      .spy_out (spy_out),
      .spy_sel (spy_sel),
      .cmp_en  (cmp_en),
      .exp_spy (post_spy),
      .exp_pc  (post_pc),
      .stall   (stall),
      .case_id (case_id),
      .errors  (err_count),
      .checks  (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                             // 20 ns period
   end

   ////////////////////////////////////////
   // Microinstruction builders

   function automatic cadr_pkg::uinst_t load_word(input logic dm, input logic [3:0] da,
                                                  input logic [15:0] k);
      cadr_pkg::uinst_t w;
      w = '0;
      w[cadr_pkg::OP_LSB +: 2]       = cadr_pkg::OP_LOAD;
      w[cadr_pkg::DEST_M_BIT]        = dm;
      w[cadr_pkg::DEST_ADR_LSB +: 4] = da;
      w[cadr_pkg::CONST_LSB +: 16]   = k;                 // Zero extended by the core
      return w;
   endfunction

   function automatic cadr_pkg::uinst_t alu_word(input cadr_pkg::aluf_e f, input logic dm,
                                                 input logic [3:0] da, input logic [3:0] aa,
                                                 input logic [3:0] ma);
      cadr_pkg::uinst_t w;
      w = '0;
      w[cadr_pkg::OP_LSB +: 2]       = cadr_pkg::OP_ALU;
      w[cadr_pkg::ALUF_LSB +: 3]     = f;
      w[cadr_pkg::DEST_M_BIT]        = dm;
      w[cadr_pkg::DEST_ADR_LSB +: 4] = da;
      w[cadr_pkg::A_ADR_LSB +: 4]    = aa;
      w[cadr_pkg::M_ADR_LSB +: 4]    = ma;
      return w;
   endfunction

   function automatic cadr_pkg::uinst_t jump_word(input cadr_pkg::jcond_e jc,
                                                  input logic [3:0] aa, input logic [3:0] ma,
                                                  input cadr_pkg::upc_t tgt);
      cadr_pkg::uinst_t w;
      w = '0;
      w[cadr_pkg::OP_LSB +: 2]                    = cadr_pkg::OP_JUMP;
      w[cadr_pkg::A_ADR_LSB +: 4]                 = aa;
      w[cadr_pkg::M_ADR_LSB +: 4]                 = ma;
      w[cadr_pkg::JCOND_LSB +: 2]                 = jc;
      w[cadr_pkg::TARGET_LSB +: cadr_pkg::UPC_W]  = tgt;
      return w;
   endfunction

   // Tag in the low half makes the IR read-back distinct per case
   function automatic cadr_pkg::uinst_t halt_word(input logic [15:0] tag);
      cadr_pkg::uinst_t w;
      w = '0;
      w[cadr_pkg::OP_LSB +: 2] = cadr_pkg::OP_HALT;
      w[15:0]                  = tag;
      return w;
   endfunction

   // Reference result of each ALU function
   function automatic cadr_pkg::word_t expected_alu(input cadr_pkg::aluf_e f,
                                                    input cadr_pkg::word_t a,
                                                    input cadr_pkg::word_t m);
      cadr_pkg::word_t r;
      case (f)
         cadr_pkg::ALU_SETA: r = a;
         cadr_pkg::ALU_SETM: r = m;
         cadr_pkg::ALU_ADD:  r = a + m;
         cadr_pkg::ALU_SUB:  r = a - m;                  // Wraps to 32 bits
         cadr_pkg::ALU_AND:  r = a & m;
         cadr_pkg::ALU_OR:   r = a | m;
         cadr_pkg::ALU_XOR:  r = a ^ m;
         default:            r = m + 32'd1;              // Increment of m
      endcase
      return r;
   endfunction

   ////////////////////////////////////////
   // Table construction

   // LOAD A[1], LOAD M[2], JUMP to 6, HALT at 3 when not taken
   task automatic add_jump_case(input int c, input cadr_pkg::jcond_e jc, input bit same);
      logic [15:0] x;
      logic [15:0] y;
      bit          taken;
      x = 16'($urandom);
      y = same ? x : (x ^ (16'($urandom) | 16'h0001));   // Nonzero xor keeps them apart
      prog[c][0] = load_word(1'b0, 4'd1, x);
      prog[c][1] = load_word(1'b1, 4'd2, y);
      prog[c][2] = jump_word(jc, 4'd1, 4'd2, 10'd6);
      prog[c][3] = halt_word(16'($urandom));
      prog[c][6] = halt_word(16'($urandom));
      case (jc)
         cadr_pkg::J_ALWAYS: taken = 1'b1;
         cadr_pkg::J_AEQM:   taken = same;
         cadr_pkg::J_ANEM:   taken = !same;
         default:            taken = 1'b0;
      endcase
      case_pc[c]  = taken ? 10'd6 : 10'd3;
      case_ob[c]  = cadr_pkg::word_t'(y);                // Last LOAD leaves ob
      case_ext[c] = 1'b0;
   endtask

   task automatic build_table();
      logic [15:0] x;
      logic [15:0] y;
      int          c;
      int          w;
      for (c = 0; c < N_CASES; c++)
         for (w = 0; w < PROG_LEN; w++)
            prog[c][w] = halt_word(16'h0000);            // Filler
      for (c = 0; c < 8; c++) begin
         x = 16'($urandom);
         y = 16'($urandom);
         prog[c][0]  = load_word(1'b0, 4'd1, x);
         prog[c][1]  = load_word(1'b1, 4'd2, y);
         prog[c][2]  = alu_word(cadr_pkg::aluf_e'(3'(c)), 1'b0, 4'd5, 4'd1, 4'd2);
         prog[c][3]  = halt_word(16'($urandom));
         case_ob[c]  = expected_alu(cadr_pkg::aluf_e'(3'(c)), cadr_pkg::word_t'(x),
                                    cadr_pkg::word_t'(y));
         case_pc[c]  = 10'd3;
         case_ext[c] = 1'b0;
      end
      add_jump_case(8,  cadr_pkg::J_AEQM,   1'b1);
      add_jump_case(9,  cadr_pkg::J_AEQM,   1'b0);
      add_jump_case(10, cadr_pkg::J_ANEM,   1'b1);
      add_jump_case(11, cadr_pkg::J_ANEM,   1'b0);
      add_jump_case(12, cadr_pkg::J_ALWAYS, 1'b0);
      add_jump_case(13, cadr_pkg::J_NEVER,  1'b1);
      // Count M[3] up to A[4], each increment read back by the next JUMP
      prog[14][0]  = load_word(1'b0, 4'd4, LOOP_N);
      prog[14][1]  = load_word(1'b1, 4'd3, 16'h0000);
      prog[14][2]  = alu_word(cadr_pkg::ALU_INCM, 1'b1, 4'd3, 4'd0, 4'd3);
      prog[14][3]  = jump_word(cadr_pkg::J_ANEM, 4'd4, 4'd3, 10'd2);
      prog[14][4]  = halt_word(16'($urandom));
      case_ob[14]  = cadr_pkg::word_t'(LOOP_N);
      case_pc[14]  = 10'd4;
      case_ext[14] = 1'b0;
      x = 16'($urandom);
      prog[15][0]  = load_word(1'b1, 4'd7, x);
      prog[15][1]  = jump_word(cadr_pkg::J_ALWAYS, 4'd0, 4'd0, 10'd1);   // Spin at 1
      case_ob[15]  = cadr_pkg::word_t'(x);
      case_pc[15]  = 10'd1;
      case_ext[15] = 1'b1;
   endtask

   ////////////////////////////////////////
   // Stimulus tasks

   task automatic wait_stop(input int limit, output bit ok);
      int i;
      ok = 1'b0;
      for (i = 0; i < limit && !ok; i++) begin
         @(posedge clk);
         #2;
         if (!machrun)
            ok = 1'b1;
      end
   endtask

   // Step spy_sel through all codes, checker compares one edge later
   task automatic readback(input cadr_pkg::upc_t pc_e, input cadr_pkg::uinst_t ir_e,
                           input cadr_pkg::word_t ob_e);
      int s;
      for (s = 0; s <= 5; s++) begin
         @(posedge clk);
         #2;
         spy_sel = cadr_pkg::spy_sel_e'(3'(s));
         post_pc = pc_e;
         cmp_en  = 1'b1;
         case (s)
            0:       post_spy = cadr_pkg::spy_t'(pc_e);
            1:       post_spy = ir_e[15:0];
            2:       post_spy = ir_e[31:16];
            3:       post_spy = ob_e[15:0];
            4:       post_spy = ob_e[31:16];
            default: post_spy = STOPPED;                  // Stopped in decode
         endcase
      end
      @(posedge clk);
      #2;
      cmp_en = 1'b0;
   endtask

   task automatic run_case(input int c);
      int w;
      bit ok;
      case_id = c;
      for (w = 0; w < PROG_LEN; w++) begin
         @(posedge clk);
         #2;
         ucode_we   = 1'b1;
         ucode_addr = cadr_pkg::upc_t'(w);
         ucode_data = prog[c][w];
      end
      @(posedge clk);
      #2;
      ucode_we = 1'b0;
      boot     = 1'b1;                                   // One-cycle pulse
      @(posedge clk);
      #2;
      boot = 1'b0;
      if (case_ext[c]) begin
         repeat (EXT_DELAY) @(posedge clk);
         #2;
         ext_halt = 1'b1;
         wait_stop(5, ok);                               // Must stop within one instruction
         ext_halt = 1'b0;
      end else begin
         wait_stop(RUN_LIMIT, ok);
      end
      if (!ok) begin
         stall = 1'b1;
         @(posedge clk);
         #2;
         stall   = 1'b0;
         stalled = 1'b1;
      end else begin
         readback(case_pc[c], prog[c][case_pc[c]], case_ob[c]);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence

   initial begin
      int c;
      void'($urandom(32'hf8e2_6d18));
      reset      = 1'b1;
      boot       = 1'b0;
      ext_halt   = 1'b0;
      ucode_we   = 1'b0;
      ucode_addr = '0;
      ucode_data = '0;
      spy_sel    = cadr_pkg::SPY_PC;
      cmp_en     = 1'b0;
      post_spy   = '0;
      post_pc    = '0;
      stall      = 1'b0;
      case_id    = -1;                                   // Reset state check
      stalled    = 1'b0;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset = 1'b0;
      repeat (2) @(posedge clk);
      readback(10'd0, '0, '0);
      for (c = 0; c < N_CASES && !stalled; c++)
         run_case(c);
      repeat (2) @(posedge clk);
      #2;
      $display("Checks run: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0 && !stalled)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG);
      $display("Result: FAILED");
      $finish;
   end

endmodule
